//--- include/xbuf_settings.svh
`ifndef XBUF_SETTINGS_SVH
`define XBUF_SETTINGS_SVH

// Rows held in the buffer
`define XB_W 4

// Elements per slot, one per consumer lane
`define XB_H 4

// Depth slots per row
`define XB_D 4

// Element width in bits
`define XB_BITW 8

// Replicas of the row and depth counters
`define XB_REP 3

// Accumulator width, wide enough for XB_D*XB_H full-scale products
`define XB_ACCW 24

`endif

//--- hdl/xbuf_pkg.sv
`default_nettype none

`include "xbuf_settings.svh"

package xbuf_pkg;

  // One unsigned element
  typedef logic [`XB_BITW-1:0] xb_elem_t;

  // Host row word, element 0 in the low bits
  typedef xb_elem_t [`XB_H*`XB_D-1:0] xb_word_t;

  // One depth slot across all rows, W rows by H lanes
  typedef xb_elem_t [`XB_W-1:0][`XB_H-1:0] xb_slice_t;

  typedef xb_elem_t [`XB_H-1:0] xb_weight_t;  // One weight per lane

  // One accumulator per row
  typedef logic [`XB_W-1:0][`XB_ACCW-1:0] xb_result_t;

  // Row count, holds 0 to XB_W
  typedef logic [$clog2(`XB_W):0] xb_rows_t;

  // Column count, holds 0 to XB_H*XB_D
  typedef logic [$clog2(`XB_H*`XB_D):0] xb_cols_t;

  // Depth slot count, holds 0 to XB_D
  typedef logic [$clog2(`XB_D):0] xb_slots_t;

  // Load controller states
  typedef enum logic [1:0] {
    IDLE,   // Waiting for start
    LOAD,   // Taking host words
    SHIFT,  // Streaming slots to the consumer
    DRAIN   // Waiting for the result pulse
  } load_state_e;

endpackage : xbuf_pkg

`default_nettype wire

//--- hdl/xbuf_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

// Control strobes and flags between load controller and X buffer
interface xbuf_ctrl_if;

  logic               clear;        // Restart pulse, zeroes store and counters
  logic               load;         // Write the host word into the next row
  logic               d_shift;      // Shift one depth slot out
  xbuf_pkg::xb_rows_t rows_lftovr;  // Zero means all rows
  xbuf_pkg::xb_cols_t cols_lftovr;  // Zero means all columns
  logic               full;         // Row limit reached
  logic               empty;        // All valid slots shifted out

  modport ctrl (
    output clear,
    output load,
    output d_shift,
    output rows_lftovr,
    output cols_lftovr,
    input  full,
    input  empty
  );

  modport buffer (
    input  clear,
    input  load,
    input  d_shift,
    input  rows_lftovr,
    input  cols_lftovr,
    output full,
    output empty
  );

endinterface : xbuf_ctrl_if

`default_nettype wire

//--- hdl/x_load_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module x_load_ctrl (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               start_i,
  input  xbuf_pkg::xb_rows_t rows_i,
  input  xbuf_pkg::xb_cols_t cols_i,
  input  logic               word_valid_i,
  output logic               load_ready_o,
  output logic               busy_o,
  input  logic               result_valid_i,
  xbuf_ctrl_if.ctrl          ctrl
);

  xbuf_pkg::load_state_e state_d, state_q;
  xbuf_pkg::xb_rows_t    rows_q;
  xbuf_pkg::xb_cols_t    cols_q;
  logic                  accept_start;

  // Start only counts in IDLE, later pulses are dropped
  assign accept_start = (state_q == xbuf_pkg::IDLE) && start_i;

  always_comb begin : next_state
    state_d = state_q;
    case (state_q)
      xbuf_pkg::IDLE: begin
        if (start_i) begin
          state_d = xbuf_pkg::LOAD;
        end
      end
      xbuf_pkg::LOAD: begin
        if (ctrl.full) begin
          state_d = xbuf_pkg::SHIFT;
        end
      end
      xbuf_pkg::SHIFT: begin
        if (ctrl.empty) begin
          state_d = xbuf_pkg::DRAIN;
        end
      end
      xbuf_pkg::DRAIN: begin
        if (result_valid_i) begin
          state_d = xbuf_pkg::IDLE;
        end
      end
      default: state_d = xbuf_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin : state_regs
    if (!arst_n_i) begin
      state_q <= xbuf_pkg::IDLE;
      rows_q  <= '0;
      cols_q  <= '0;
    end else begin
      state_q <= state_d;
      if (accept_start) begin  // Leftovers stay fixed for the whole job
        rows_q <= rows_i;
        cols_q <= cols_i;
      end
    end
  end

  // Host may only write while the buffer has room
  assign load_ready_o = (state_q == xbuf_pkg::LOAD) && !ctrl.full;
  assign busy_o       = (state_q != xbuf_pkg::IDLE);

  assign ctrl.clear       = accept_start;
  assign ctrl.load        = word_valid_i && load_ready_o;  // Other strobes are ignored
  assign ctrl.d_shift     = (state_q == xbuf_pkg::SHIFT) && !ctrl.empty;
  assign ctrl.rows_lftovr = rows_q;
  assign ctrl.cols_lftovr = cols_q;

  // Store can't be written and shifted in the same cycle
  a_load_shift_excl: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    !(ctrl.load && ctrl.d_shift)
  ) else $error("x_load_ctrl: load and d_shift high together");

endmodule : x_load_ctrl

`default_nettype wire

//--- hdl/x_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbuf_settings.svh"

module x_buffer (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  xbuf_pkg::xb_word_t  word_i,
  xbuf_ctrl_if.buffer         ctrl,
  output xbuf_pkg::xb_slice_t slice_o,
  output logic                slice_valid_o,
  output logic                slice_last_o,
  output logic                fault_o
);

  localparam int unsigned TOT_COLS = `XB_H * `XB_D;

  // Row index and depth count share one vote
  typedef struct packed {
    xbuf_pkg::xb_rows_t  row;
    xbuf_pkg::xb_slots_t dep;
  } cnt_t;

  xbuf_pkg::xb_rows_t  row_lim;
  xbuf_pkg::xb_cols_t  col_lim;
  xbuf_pkg::xb_slots_t slot_lim;

  cnt_t cnt_v [`XB_REP];  // Per-replica next value
  cnt_t cnt_q [`XB_REP];
  cnt_t cnt_d;            // Voted next value
  logic vote_mismatch;
  logic fault_q;

  xbuf_pkg::xb_slice_t [`XB_D-1:0] pad_d, pad_q;  // Padded store, slot 0 leaves first
  xbuf_pkg::xb_slice_t             slice_d, slice_q;
  logic                            valid_q, last_q;

  // Zero or out-of-range leftovers select the full size
  assign row_lim = (ctrl.rows_lftovr == '0 || ctrl.rows_lftovr > `XB_W) ?
                   xbuf_pkg::xb_rows_t'(`XB_W) : ctrl.rows_lftovr;
  assign col_lim = (ctrl.cols_lftovr == '0 || ctrl.cols_lftovr > TOT_COLS) ?
                   xbuf_pkg::xb_cols_t'(TOT_COLS) : ctrl.cols_lftovr;

  // Slots needed to cover col_lim, rounded up
  assign slot_lim = xbuf_pkg::xb_slots_t'((col_lim + (`XB_H - 1)) / `XB_H);

  for (genvar r = 0; r < `XB_REP; r++) begin : gen_cnt_next
    always_comb begin
      cnt_v[r] = cnt_q[r];
      if (ctrl.clear) begin
        cnt_v[r] = '0;
      end else begin
        if (ctrl.load && cnt_q[r].row != row_lim) begin
          cnt_v[r].row = cnt_q[r].row + 1'b1;
        end
        if (ctrl.d_shift && cnt_q[r].dep != slot_lim) begin
          cnt_v[r].dep = cnt_q[r].dep + 1'b1;
        end
      end
    end
  end

  // Bitwise majority over the replicas
  always_comb begin : vote
    int unsigned ones;
    for (int b = 0; b < $bits(cnt_t); b++) begin
      ones = 0;
      for (int r = 0; r < `XB_REP; r++) begin
        ones += cnt_v[r][b];
      end
      cnt_d[b] = (2 * ones > `XB_REP);
    end
  end

  always_comb begin : mismatch
    vote_mismatch = 1'b0;
    for (int r = 0; r < `XB_REP; r++) begin
      if (cnt_v[r] != cnt_d) begin
        vote_mismatch = 1'b1;
      end
    end
  end

  // All replicas agree after the vote, replica 0 drives the datapath
  assign ctrl.full  = (cnt_q[0].row == row_lim);
  assign ctrl.empty = (cnt_q[0].dep == slot_lim);

  always_comb begin : pad_next
    pad_d   = pad_q;
    slice_d = slice_q;
    if (ctrl.clear) begin
      pad_d = '0;  // Rows that never get loaded must read as zero
    end else if (ctrl.load) begin
      for (int w = 0; w < `XB_W; w++) begin
        if (cnt_q[0].row == w) begin
          for (int d = 0; d < `XB_D; d++) begin
            for (int h = 0; h < `XB_H; h++) begin
              pad_d[d][w][h] = ((`XB_H * d + h) < col_lim) ? word_i[`XB_H * d + h] : '0;
            end
          end
        end
      end
    end else if (ctrl.d_shift) begin
      for (int d = 0; d < `XB_D - 1; d++) begin
        pad_d[d] = pad_q[d + 1];
      end
      pad_d[`XB_D-1] = '0;  // Zero refill at the top
      slice_d        = pad_q[0];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin : ctrl_regs
    if (!arst_n_i) begin
      cnt_q   <= '{default: '0};
      fault_q <= 1'b0;
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      for (int r = 0; r < `XB_REP; r++) begin
        cnt_q[r] <= cnt_d;
      end
      fault_q <= vote_mismatch;
      valid_q <= ctrl.d_shift;
      last_q  <= ctrl.d_shift && (cnt_q[0].dep + 1'b1 == slot_lim);  // Final slot of the job
    end
  end

  always_ff @(posedge clk_i) begin : data_regs
    pad_q   <= pad_d;
    slice_q <= slice_d;
  end

  assign slice_o       = slice_q;
  assign slice_valid_o = valid_q;
  assign slice_last_o  = last_q;
  assign fault_o       = fault_q;

  // Controller must respect the buffer flags
  a_no_load_full: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    ctrl.full |-> !ctrl.load
  ) else $error("x_buffer: load while full");

  a_no_shift_empty: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    ctrl.empty |-> !ctrl.d_shift
  ) else $error("x_buffer: d_shift while empty");

endmodule : x_buffer

`default_nettype wire

//--- hdl/x_dot_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbuf_settings.svh"

module x_dot_unit (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 clear_i,
  input  xbuf_pkg::xb_weight_t weight_i,
  input  xbuf_pkg::xb_slice_t  slice_i,
  input  logic                 slice_valid_i,
  input  logic                 slice_last_i,
  output xbuf_pkg::xb_result_t result_o,
  output logic                 result_valid_o
);

  xbuf_pkg::xb_result_t row_sum;  // Lane products summed per row
  xbuf_pkg::xb_result_t acc_q;
  logic                 done_q;

  always_comb begin : lane_sum
    for (int w = 0; w < `XB_W; w++) begin
      row_sum[w] = '0;
      for (int h = 0; h < `XB_H; h++) begin
        row_sum[w] += `XB_ACCW'(slice_i[w][h]) * `XB_ACCW'(weight_i[h]);
      end
    end
  end

  // Accumulators hold the result until the next job clears them
  always_ff @(posedge clk_i) begin : acc_regs
    if (clear_i) begin
      acc_q <= '0;
    end else if (slice_valid_i) begin
      for (int w = 0; w < `XB_W; w++) begin
        acc_q[w] <= acc_q[w] + row_sum[w];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin : done_reg
    if (!arst_n_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= slice_valid_i && slice_last_i;  // Sums complete on the same edge
    end
  end

  assign result_o       = acc_q;
  assign result_valid_o = done_q;

  // Buffer marks only one slice per job as last
  a_result_pulse: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    result_valid_o |=> !result_valid_o
  ) else $error("x_dot_unit: result_valid_o longer than one cycle");

endmodule : x_dot_unit

`default_nettype wire

//--- hdl/xbuf_top.sv
`timescale 1ns/1ps
`default_nettype none

module xbuf_top (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 start_i,
  input  xbuf_pkg::xb_rows_t   rows_i,      // Row leftover, zero for all rows
  input  xbuf_pkg::xb_cols_t   cols_i,      // Column leftover, zero for all columns
  input  logic                 word_valid_i,
  input  xbuf_pkg::xb_word_t   word_i,
  input  xbuf_pkg::xb_weight_t weight_i,
  output logic                 load_ready_o,
  output logic                 busy_o,
  output xbuf_pkg::xb_result_t result_o,
  output logic                 result_valid_o,
  output logic                 fault_o
);

  xbuf_pkg::xb_slice_t slice;
  logic                slice_valid;
  logic                slice_last;

  xbuf_ctrl_if ctrl_if ();

  // Producer, turns host strobes into buffer control
  x_load_ctrl i_load_ctrl (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .start_i        ( start_i        ),
    .rows_i         ( rows_i         ),
    .cols_i         ( cols_i         ),
    .word_valid_i   ( word_valid_i   ),
    .load_ready_o   ( load_ready_o   ),
    .busy_o         ( busy_o         ),
    .result_valid_i ( result_valid_o ),
    .ctrl           ( ctrl_if.ctrl   )
  );

  x_buffer i_x_buffer (
    .clk_i         ( clk_i          ),
    .arst_n_i      ( arst_n_i       ),
    .word_i        ( word_i         ),
    .ctrl          ( ctrl_if.buffer ),
    .slice_o       ( slice          ),
    .slice_valid_o ( slice_valid    ),
    .slice_last_o  ( slice_last     ),
    .fault_o       ( fault_o        )
  );

  // Consumer, cleared together with the buffer
  x_dot_unit i_dot_unit (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .clear_i        ( ctrl_if.clear  ),
    .weight_i       ( weight_i       ),
    .slice_i        ( slice          ),
    .slice_valid_i  ( slice_valid    ),
    .slice_last_i   ( slice_last     ),
    .result_o       ( result_o       ),
    .result_valid_o ( result_valid_o )
  );

endmodule : xbuf_top

`default_nettype wire

//--- sim/tb_xbuf_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbuf_settings.svh"

module tb_xbuf_top;

  localparam int NUM_JOBS = 40;
  localparam int MAX_GAP  = 3;
  localparam int TOT_COLS = `XB_H * `XB_D;
  // Start, gapped loads, full, shift-out and result pulse, plus slack
  localparam int JOB_CYCLES = 1 + `XB_W * (MAX_GAP + 1) + `XB_D + 8;
  localparam int TIMEOUT_NS = (NUM_JOBS * JOB_CYCLES + 20) * 4;

  logic                 clk_i;
  logic                 arst_n_i;
  logic                 start_i;
  xbuf_pkg::xb_rows_t   rows_i;
  xbuf_pkg::xb_cols_t   cols_i;
  logic                 word_valid_i;
  xbuf_pkg::xb_word_t   word_i;
  xbuf_pkg::xb_weight_t weight_i;
  logic                 load_ready_o;
  logic                 busy_o;
  xbuf_pkg::xb_result_t result_o;
  logic                 result_valid_o;
  logic                 fault_o;

  xbuf_pkg::xb_word_t   words [`XB_W];  // Rows the model holds
  xbuf_pkg::xb_result_t exp_result;
  int                   exp_rows;
  int                   exp_cols;
  int                   sent_cnt;       // Words accepted in the current job
  int                   start_cnt = 0;
  int                   result_cnt = 0;
  logic                 job_start;      // Marks the one real start of a job

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  xbuf_top dut0 (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .start_i        ( start_i        ),
    .rows_i         ( rows_i         ),
    .cols_i         ( cols_i         ),
    .word_valid_i   ( word_valid_i   ),
    .word_i         ( word_i         ),
    .weight_i       ( weight_i       ),
    .load_ready_o   ( load_ready_o   ),
    .busy_o         ( busy_o         ),
    .result_o       ( result_o       ),
    .result_valid_o ( result_valid_o ),
    .fault_o        ( fault_o        )
  );

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_value(input string sig, input logic [127:0] expected,
                              input logic [127:0] actual);
    $display("error at %0t ns: %s expected %0h, got %0h", $time, sig, expected, actual);
    abort_run();
  endtask

  task automatic report_event(input string what);
    $display("failure at %0t ns: %s", $time, what);
    abort_run();
  endtask

  function automatic xbuf_pkg::xb_word_t rand_word();
    xbuf_pkg::xb_word_t w;
    for (int i = 0; i < TOT_COLS; i++) begin
      w[i] = xbuf_pkg::xb_elem_t'($urandom);
    end
    return w;
  endfunction

  // Valid element times the weight of its lane, summed per row
  function automatic xbuf_pkg::xb_result_t model_result();
    xbuf_pkg::xb_result_t res;
    res = '0;
    for (int r = 0; r < exp_rows; r++) begin
      for (int c = 0; c < exp_cols; c++) begin
        res[r] += `XB_ACCW'(words[r][c]) * `XB_ACCW'(weight_i[c % `XB_H]);
      end
    end
    return res;
  endfunction

  // Host noise that a busy DUT must ignore
  task automatic drive_ignored_start();
    start_i = ($urandom_range(0, 3) == 0);
    rows_i  = xbuf_pkg::xb_rows_t'($urandom_range(0, `XB_W));
    cols_i  = xbuf_pkg::xb_cols_t'($urandom_range(0, TOT_COLS));
  endtask

  task automatic run_job(input bit full_size);
    int rows;
    int cols;
    int gap;
    rows = full_size ? 0 : $urandom_range(0, `XB_W);
    cols = full_size ? 0 : $urandom_range(0, TOT_COLS);
    exp_rows = (rows == 0) ? `XB_W : rows;  // Zero leftover means full size
    exp_cols = (cols == 0) ? TOT_COLS : cols;
    sent_cnt = 0;
    for (int r = 0; r < `XB_W; r++) begin
      words[r] = '0;
    end
    @(negedge clk_i);
    start_i      = 1'b1;
    job_start    = 1'b1;
    rows_i       = xbuf_pkg::xb_rows_t'(rows);
    cols_i       = xbuf_pkg::xb_cols_t'(cols);
    word_valid_i = 1'b1;  // Dropped, DUT is still idle
    word_i       = rand_word();
    for (int h = 0; h < `XB_H; h++) begin
      weight_i[h] = xbuf_pkg::xb_elem_t'($urandom);
    end
    start_cnt++;
    @(negedge clk_i);
    job_start = 1'b0;
    gap = $urandom_range(0, MAX_GAP);
    while (sent_cnt < exp_rows) begin
      if (gap > 0) begin
        word_valid_i = 1'b0;
        gap--;
      end else begin
        word_valid_i = 1'b1;
        word_i       = rand_word();
        if (load_ready_o) begin
          words[sent_cnt] = word_i;
          sent_cnt++;
          gap = $urandom_range(0, MAX_GAP);
        end
      end
      drive_ignored_start();
      @(negedge clk_i);
    end
    exp_result = model_result();
    while (!result_valid_o) begin
      word_valid_i = ($urandom_range(0, 1) == 1);  // Strobes while not ready
      word_i       = rand_word();
      drive_ignored_start();
      @(negedge clk_i);
    end
    start_i      = 1'b0;
    word_valid_i = 1'b0;
  endtask

  always @(posedge clk_i) begin
    if (result_valid_o) begin
      result_cnt <= result_cnt + 1;
    end
  end

  a_result: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    result_valid_o |-> result_o == exp_result)
    else report_value("result_o", $sampled(exp_result), $sampled(result_o));

  // Ready drops exactly when the row limit is reached
  a_ready_count: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $fell(load_ready_o) |-> sent_cnt == exp_rows)
    else report_value("load_ready_o", $sampled(exp_rows), $sampled(sent_cnt));

  a_ready_limit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    load_ready_o |-> (sent_cnt - int'(word_valid_i)) < exp_rows)
    else report_event("load_ready_o still high after the row limit was loaded");

  a_busy_start: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    job_start |=> busy_o)
    else report_value("busy_o", 1, $sampled(busy_o));

  a_busy_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    busy_o && !result_valid_o |=> busy_o)
    else report_event("busy_o fell before result_valid_o");

  a_busy_end: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    result_valid_o |=> !busy_o)
    else report_event("busy_o still high after result_valid_o");

  a_result_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    result_valid_o |=> !result_valid_o)
    else report_event("result_valid_o high for more than one cycle");

  a_one_result: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    result_valid_o |-> start_cnt == result_cnt + 1)
    else report_value("result_valid_o count", $sampled(start_cnt),
                      $sampled(result_cnt) + 1);

  a_no_fault: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !fault_o)
    else report_value("fault_o", 0, 1);

  a_reset_low: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> !busy_o && !load_ready_o && !result_valid_o && !fault_o)
    else report_event("control outputs not low after reset");

  initial begin : watchdog
    #(TIMEOUT_NS);
    report_event("timeout, the DUT stopped answering");
  end

  initial begin
    void'($urandom(6258));
    arst_n_i     = 1'b0;
    start_i      = 1'b0;
    rows_i       = '0;
    cols_i       = '0;
    word_valid_i = 1'b0;
    word_i       = '0;
    weight_i     = '0;
    job_start    = 1'b0;
    exp_result   = '0;
    exp_rows     = `XB_W;
    exp_cols     = TOT_COLS;
    sent_cnt     = 0;
    repeat (2) @(negedge clk_i);
    arst_n_i = 1'b1;
    run_job(1'b1);  // Full size first
    for (int j = 1; j < NUM_JOBS; j++) begin
      run_job(1'b0);
    end
    @(negedge clk_i);
    $display("Done: no errors");
    $finish;
  end

endmodule : tb_xbuf_top

`default_nettype wire

//--- xbuf_top.f
+incdir+include
hdl/xbuf_pkg.sv
hdl/xbuf_ctrl_if.sv
hdl/x_load_ctrl.sv
hdl/x_buffer.sv
hdl/x_dot_unit.sv
hdl/xbuf_top.sv
sim/tb_xbuf_top.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	  -f xbuf_top.f --top-module tb_xbuf_top --Mdir obj_dir -o tb_xbuf_top
	-./obj_dir/tb_xbuf_top > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Done: no errors" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
